// ==== include/pkt_proc_config.svh ====
// widths and depths for the packet processing stage
// buffer depth bounds the longest packet, 2**PP_BUF_ADDR_WIDTH words
// fifo depth exponent is only a default, input_fifo may override it

`ifndef PKT_PROC_CONFIG_SVH
`define PKT_PROC_CONFIG_SVH

// data lane, one network word
`define PP_DATA_WIDTH 64

// control lane, non-zero marks packet start or end
`define PP_CTRL_WIDTH 8

// packet buffer address, 256 words
`define PP_BUF_ADDR_WIDTH 8

// input fifo depth exponent, 4 entries
// nearly full leaves one slot for a word in flight
`define PP_FIFO_DEPTH_BITS 2

`endif

// ==== hw/pkt_proc_pkg.sv ====
// shared types for the packet stage
// a stored word keeps the control byte above the data word

`include "pkt_proc_config.svh"

package pkt_proc_pkg;

   // one lane each
   typedef logic [`PP_DATA_WIDTH-1:0] data_t;
   typedef logic [`PP_CTRL_WIDTH-1:0] ctrl_t;

   // fifo and buffer entry, {ctrl, data}
   typedef logic [`PP_CTRL_WIDTH+`PP_DATA_WIDTH-1:0] word_t;

   // buffer address, also an offset from packet start
   typedef logic [`PP_BUF_ADDR_WIDTH-1:0] buf_addr_t;

   // sequencer states
   typedef enum logic [1:0] {
      seek_header,
      store_payload,
      wait_proc,
      drain
   } seq_state_e;

endpackage

// ==== hw/input_fifo.sv ====
// fall-through fifo, head word visible before it is read
// nearly_full rises with one free entry left
// writer must honour nearly_full, reader must check empty

`timescale 1ns/100ps
`include "pkt_proc_config.svh"

module input_fifo #(
   parameter int depth_bits = `PP_FIFO_DEPTH_BITS
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                wr_en,
   input  pkt_proc_pkg::word_t wr_word,
   input  logic                rd_en,
   output pkt_proc_pkg::word_t head_word,
   output logic                empty,
   output logic                nearly_full
);

   localparam int depth = 2 ** depth_bits;

   pkt_proc_pkg::word_t   store [depth];
   logic [depth_bits-1:0] wr_ptr;
   logic [depth_bits-1:0] rd_ptr;
   logic [depth_bits:0]   count;
   logic                  full;

   //////////////////////////////////////////////////////////////////////
   // storage
   //////////////////////////////////////////////////////////////////////

   // payload only, pointers carry the validity
   always_ff @(posedge clk) begin
      if (wr_en) begin
         store[wr_ptr] <= wr_word;
      end
   end

   // head is the oldest entry, no read latency
   assign head_word = store[rd_ptr];

   //////////////////////////////////////////////////////////////////////
   // pointers and fill level
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // pointers wrap on their own
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // simultaneous read and write keeps the level
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign empty       = (count == '0);
   assign full        = (count == (depth_bits+1)'(depth));
   assign nearly_full = (count >= (depth_bits+1)'(depth - 1));

   // overflow would silently drop a word
   a_no_write_full : assert property (@(posedge clk) disable iff (reset)
      wr_en |-> !full);

   // underflow would replay a stale head
   a_no_read_empty : assert property (@(posedge clk) disable iff (reset)
      rd_en |-> !empty);

endmodule

// ==== hw/packet_buffer.sv ====
// packet store, one write port and one registered read port
// read data appears one cycle after rd_addr
// contents are undefined after power up

`timescale 1ns/100ps
`include "pkt_proc_config.svh"

module packet_buffer (
   input  logic                    clk,
   input  logic                    wr_en,
   input  pkt_proc_pkg::buf_addr_t wr_addr,
   input  pkt_proc_pkg::word_t     wr_word,
   input  pkt_proc_pkg::buf_addr_t rd_addr,
   output pkt_proc_pkg::word_t     rd_word
);

   localparam int depth = 2 ** `PP_BUF_ADDR_WIDTH;

   // 256 x 72, block ram shape
   pkt_proc_pkg::word_t mem [depth];

   //////////////////////////////////////////////////////////////////////
   // write port
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_word;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // read port
   //////////////////////////////////////////////////////////////////////

   // same address write and read returns old data
   always_ff @(posedge clk) begin
      rd_word <= mem[rd_addr];
   end

endmodule

// ==== hw/packet_sequencer.sv ====
// packet fsm, buffer pointers and port arbitration
// packets longer than the buffer are not supported
// buffer is empty between packets, rd_ptr marks the packet start
// processor may touch the buffer only while proc_req high and proc_ack low

`timescale 1ns/100ps
`include "pkt_proc_config.svh"

module packet_sequencer (
   input  logic                    clk,
   input  logic                    reset,
   // input fifo
   input  pkt_proc_pkg::word_t     head_word,
   input  logic                    fifo_empty,
   output logic                    fifo_rd,
   output logic                    accept_en,
   // packet buffer
   output logic                    buf_wr_en,
   output pkt_proc_pkg::buf_addr_t buf_wr_addr,
   output pkt_proc_pkg::word_t     buf_wr_word,
   output pkt_proc_pkg::buf_addr_t buf_rd_addr,
   input  pkt_proc_pkg::word_t     buf_rd_word,
   // downstream
   output pkt_proc_pkg::data_t     out_data,
   output pkt_proc_pkg::ctrl_t     out_ctrl,
   output logic                    out_wr,
   input  logic                    out_rdy,
   // external processor
   output logic                    proc_req,
   input  logic                    proc_ack,
   input  logic                    proc_wr_en,
   input  pkt_proc_pkg::buf_addr_t proc_addr,
   input  pkt_proc_pkg::word_t     proc_wdata,
   output pkt_proc_pkg::word_t     proc_rdata
);

   pkt_proc_pkg::seq_state_e state;
   pkt_proc_pkg::seq_state_e state_next;
   pkt_proc_pkg::buf_addr_t  wr_ptr;
   pkt_proc_pkg::buf_addr_t  rd_ptr;
   pkt_proc_pkg::buf_addr_t  proc_buf_addr;
   logic                     head_is_ctrl;
   logic                     store_word;
   logic                     eop_stored;
   logic                     proc_owns;
   logic                     req_set;
   logic                     req_clr;
   logic                     drain_rd;
   logic                     drain_done;

   // start or end marker on the head word
   assign head_is_ctrl = (head_word[`PP_DATA_WIDTH +: `PP_CTRL_WIDTH] != '0);

   //////////////////////////////////////////////////////////////////////
   // state machine
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      state_next = state;
      fifo_rd    = 1'b0;
      store_word = 1'b0;
      case (state)
         pkt_proc_pkg::seek_header: begin
            // junk before a start is popped and dropped
            if (!fifo_empty) begin
               fifo_rd = 1'b1;
               if (head_is_ctrl) begin
                  store_word = 1'b1;
                  state_next = pkt_proc_pkg::store_payload;
               end
            end
         end
         pkt_proc_pkg::store_payload: begin
            // every word stored, the next marker closes the packet
            if (!fifo_empty) begin
               fifo_rd    = 1'b1;
               store_word = 1'b1;
               if (head_is_ctrl) begin
                  state_next = pkt_proc_pkg::wait_proc;
               end
            end
         end
         pkt_proc_pkg::wait_proc: begin
            if (req_clr) begin
               state_next = pkt_proc_pkg::drain;
            end
         end
         pkt_proc_pkg::drain: begin
            if (drain_done) begin
               state_next = pkt_proc_pkg::seek_header;
            end
         end
         default: state_next = pkt_proc_pkg::seek_header;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= pkt_proc_pkg::seek_header;
      end else begin
         state <= state_next;
      end
   end

   // upstream held off while the packet is out of our hands
   assign accept_en = (state != pkt_proc_pkg::wait_proc) && (state != pkt_proc_pkg::drain);

   //////////////////////////////////////////////////////////////////////
   // processor handshake, four phase
   //////////////////////////////////////////////////////////////////////

   assign eop_stored = store_word && head_is_ctrl && (state == pkt_proc_pkg::store_payload);

   // raise right after the end word, or later once ack is back low
   assign req_set = !proc_req && !proc_ack
                    && (eop_stored || state == pkt_proc_pkg::wait_proc);
   assign req_clr = proc_req && proc_ack && (state == pkt_proc_pkg::wait_proc);

   always_ff @(posedge clk) begin
      if (reset) begin
         proc_req <= 1'b0;
      end else if (req_set) begin
         proc_req <= 1'b1;
      end else if (req_clr) begin
         proc_req <= 1'b0;
      end
   end

   // processor window
   assign proc_owns = (state == pkt_proc_pkg::wait_proc) && proc_req && !proc_ack;

   // offsets are relative to the packet start
   assign proc_buf_addr = pkt_proc_pkg::buf_addr_t'(rd_ptr + proc_addr);

   //////////////////////////////////////////////////////////////////////
   // pointers and drain
   //////////////////////////////////////////////////////////////////////

   // one read per ready cycle while words remain
   assign drain_rd   = (state == pkt_proc_pkg::drain) && out_rdy && (rd_ptr != wr_ptr);
   assign drain_done = (rd_ptr == wr_ptr);

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         out_wr <= 1'b0;
      end else begin
         if (store_word) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (drain_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // lines up with the registered buffer read
         out_wr <= drain_rd;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // buffer port arbitration
   //////////////////////////////////////////////////////////////////////

   // store path in the input states, processor path in its window
   assign buf_wr_en   = store_word || (proc_owns && proc_wr_en);
   assign buf_wr_addr = proc_owns ? proc_buf_addr : wr_ptr;
   assign buf_wr_word = proc_owns ? proc_wdata : head_word;
   assign buf_rd_addr = proc_owns ? proc_buf_addr : rd_ptr;

   // read data shared by processor and output
   assign proc_rdata = buf_rd_word;
   assign out_data   = buf_rd_word[`PP_DATA_WIDTH-1:0];
   assign out_ctrl   = buf_rd_word[`PP_DATA_WIDTH +: `PP_CTRL_WIDTH];

   //////////////////////////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////////////////////////

   // a new request waits for the previous ack to clear
   a_req_after_ack_low : assert property (@(posedge clk) disable iff (reset)
      (!proc_req && proc_ack) |=> !proc_req);

   // output words come only from a drain
   a_out_wr_in_drain : assert property (@(posedge clk) disable iff (reset)
      out_wr |-> (state == pkt_proc_pkg::drain || $past(state) == pkt_proc_pkg::drain));

   // nothing overwrites a packet that is leaving
   a_no_write_in_drain : assert property (@(posedge clk) disable iff (reset)
      (state == pkt_proc_pkg::drain) |-> !buf_wr_en);

endmodule

// ==== hw/pkt_proc_top.sv ====
// packet processing stage, 64 bit data with 8 bit control
// in_wr only while in_rdy is high
// out_wr follows a cycle with out_rdy high by one cycle
// processor owns the buffer between proc_req rise and proc_ack rise

`timescale 1ns/100ps

module pkt_proc_top (
   input  logic                    clk,
   input  logic                    reset,
   // upstream
   input  pkt_proc_pkg::data_t     in_data,
   input  pkt_proc_pkg::ctrl_t     in_ctrl,
   input  logic                    in_wr,
   output logic                    in_rdy,
   // downstream
   output pkt_proc_pkg::data_t     out_data,
   output pkt_proc_pkg::ctrl_t     out_ctrl,
   output logic                    out_wr,
   input  logic                    out_rdy,
   // external processor
   output logic                    proc_req,
   input  logic                    proc_ack,
   input  logic                    proc_wr_en,
   input  pkt_proc_pkg::buf_addr_t proc_addr,
   input  pkt_proc_pkg::word_t     proc_wdata,
   output pkt_proc_pkg::word_t     proc_rdata
);

   pkt_proc_pkg::word_t     in_word;
   pkt_proc_pkg::word_t     head_word;
   logic                    fifo_empty;
   logic                    fifo_nearly_full;
   logic                    fifo_rd;
   logic                    accept_en;
   logic                    buf_wr_en;
   pkt_proc_pkg::buf_addr_t buf_wr_addr;
   pkt_proc_pkg::buf_addr_t buf_rd_addr;
   pkt_proc_pkg::word_t     buf_wr_word;
   pkt_proc_pkg::word_t     buf_rd_word;

   // control byte on top
   assign in_word = {in_ctrl, in_data};

   // fifo room and fsm state both gate the upstream
   assign in_rdy = accept_en && !fifo_nearly_full;

   input_fifo i_input_fifo (
      .clk (clk), .reset (reset),
      .wr_en (in_wr), .wr_word (in_word), .rd_en (fifo_rd),
      .head_word (head_word), .empty (fifo_empty), .nearly_full (fifo_nearly_full)
   );

   packet_sequencer i_packet_sequencer (
      .clk (clk), .reset (reset),
      .head_word (head_word), .fifo_empty (fifo_empty),
      .fifo_rd (fifo_rd), .accept_en (accept_en),
      .buf_wr_en (buf_wr_en), .buf_wr_addr (buf_wr_addr), .buf_wr_word (buf_wr_word),
      .buf_rd_addr (buf_rd_addr), .buf_rd_word (buf_rd_word),
      .out_data (out_data), .out_ctrl (out_ctrl), .out_wr (out_wr), .out_rdy (out_rdy),
      .proc_req (proc_req), .proc_ack (proc_ack), .proc_wr_en (proc_wr_en),
      .proc_addr (proc_addr), .proc_wdata (proc_wdata), .proc_rdata (proc_rdata)
   );

   packet_buffer i_packet_buffer (
      .clk (clk),
      .wr_en (buf_wr_en), .wr_addr (buf_wr_addr), .wr_word (buf_wr_word),
      .rd_addr (buf_rd_addr), .rd_word (buf_rd_word)
   );

endmodule

// ==== dv/pkt_proc_tb.sv ====
// random packets through the stage against a queue model
// processor agent edits each packet at random offsets before the drain
// inputs change and outputs are sampled 1 ns after the rising edge
// packets of 2 to 40 words always fit the 256 word buffer

`timescale 1ns/100ps
`include "pkt_proc_config.svh"

module pkt_proc_tb;

   localparam int num_pkts    = 12;
   localparam int max_len     = 40;
   localparam int cycle_limit = num_pkts * (4 * max_len + 64);

   logic                    clk;
   logic                    reset;
   pkt_proc_pkg::data_t     in_data;
   pkt_proc_pkg::ctrl_t     in_ctrl;
   logic                    in_wr;
   logic                    in_rdy;
   pkt_proc_pkg::data_t     out_data;
   pkt_proc_pkg::ctrl_t     out_ctrl;
   logic                    out_wr;
   logic                    out_rdy;
   logic                    proc_req;
   logic                    proc_ack;
   logic                    proc_wr_en;
   pkt_proc_pkg::buf_addr_t proc_addr;
   pkt_proc_pkg::word_t     proc_wdata;
   pkt_proc_pkg::word_t     proc_rdata;

   // model queues for words as driven, packet lengths and expected output
   pkt_proc_pkg::word_t     sent_q [$];
   int                      len_q [$];
   pkt_proc_pkg::word_t     exp_q [$];
   pkt_proc_pkg::word_t     cur_pkt [256];

   int                      pkts_sent;
   int                      pkts_done;
   int                      req_count;
   int                      error_count;
   int                      check_count;
   int                      pkt_words;
   int                      err_base;
   int                      cycles;
   logic                    holding;
   logic                    prev_req;
   logic                    prev_out_rdy;
   int unsigned             seed_value;

   pkt_proc_top i_pkt_proc_top (
      .clk (clk), .reset (reset),
      .in_data (in_data), .in_ctrl (in_ctrl), .in_wr (in_wr), .in_rdy (in_rdy),
      .out_data (out_data), .out_ctrl (out_ctrl), .out_wr (out_wr), .out_rdy (out_rdy),
      .proc_req (proc_req), .proc_ack (proc_ack), .proc_wr_en (proc_wr_en),
      .proc_addr (proc_addr), .proc_wdata (proc_wdata), .proc_rdata (proc_rdata)
   );

   // 10 ns clock
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // compare helpers
   //////////////////////////////////////////////////////////////////////

   task automatic check_word(input pkt_proc_pkg::word_t actual,
                             input pkt_proc_pkg::word_t expected, input string what);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("** Error %0t: %s, got %h expected %h", $time, what, actual, expected);
      end
   endtask

   task automatic check_flag(input logic actual, input logic expected, input string what);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("** Error %0t: %s, got %b expected %b", $time, what, actual, expected);
      end
   endtask

   function automatic pkt_proc_pkg::data_t random_data();
      return {$urandom, $urandom};
   endfunction

   //////////////////////////////////////////////////////////////////////
   // upstream driver
   //////////////////////////////////////////////////////////////////////

   // one word per call with random idle cycles and only while in_rdy
   task automatic drive_word(input pkt_proc_pkg::word_t w);
      logic done;
      done = 1'b0;
      while (!done) begin
         @(posedge clk);
         #1;
         if (in_rdy && ($urandom_range(3) != 0)) begin
            {in_ctrl, in_data} = w;
            in_wr = 1'b1;
            done  = 1'b1;
         end else begin
            in_wr = 1'b0;
         end
      end
   endtask

   task automatic send_packets();
      int                  p;
      int                  i;
      int                  len;
      pkt_proc_pkg::ctrl_t ctrl;
      pkt_proc_pkg::word_t w;
      for (p = 0; p < num_pkts; p++) begin
         // zero-control junk that the stage drops before the start word
         repeat ($urandom_range(3)) drive_word({pkt_proc_pkg::ctrl_t'(0), random_data()});
         len = $urandom_range(max_len, 2);
         len_q.push_back(len);
         for (i = 0; i < len; i++) begin
            ctrl = '0;
            // start and end words carry a marker
            if (i == 0 || i == len - 1) begin
               ctrl = pkt_proc_pkg::ctrl_t'($urandom_range((1 << `PP_CTRL_WIDTH) - 1, 1));
            end
            w = {ctrl, random_data()};
            sent_q.push_back(w);
            drive_word(w);
         end
         pkts_sent++;
      end
      @(posedge clk);
      #1;
      in_wr = 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // processor agent
   //////////////////////////////////////////////////////////////////////

   task automatic run_agent();
      int                  p;
      int                  i;
      int                  len;
      int                  ops;
      int                  offset;
      logic                is_write;
      pkt_proc_pkg::word_t wdata;
      for (p = 0; p < num_pkts; p++) begin
         while (!proc_req) begin
            @(posedge clk);
            #1;
         end
         len = len_q.pop_front();
         for (i = 0; i < len; i++) begin
            cur_pkt[i] = sent_q.pop_front();
         end
         repeat ($urandom_range(4)) begin
            @(posedge clk);
            #1;
         end
         // zero ops leaves the packet untouched
         ops = $urandom_range(6);
         for (i = 0; i < ops; i++) begin
            offset     = $urandom_range(len - 1);
            is_write   = $urandom_range(1);
            wdata      = {pkt_proc_pkg::ctrl_t'($urandom), random_data()};
            proc_addr  = pkt_proc_pkg::buf_addr_t'(offset);
            proc_wr_en = is_write;
            proc_wdata = wdata;
            if (is_write) begin
               cur_pkt[offset] = wdata;
            end
            @(posedge clk);
            #1;
            // read data for the offset of the previous cycle
            if (!is_write) begin
               check_word(proc_rdata, cur_pkt[offset], "processor read");
            end
         end
         proc_wr_en = 1'b0;
         for (i = 0; i < len; i++) begin
            exp_q.push_back(cur_pkt[i]);
         end
         proc_ack = 1'b1;
         @(posedge clk);
         #1;
         check_flag(proc_req, 1'b0, "proc_req one cycle after proc_ack");
         proc_ack = 1'b0;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // output monitor and out_rdy
   //////////////////////////////////////////////////////////////////////

   task automatic watch_output();
      pkt_proc_pkg::word_t got;
      forever begin
         @(posedge clk);
         #1;
         // a word needs out_rdy high at the edge before
         if (out_wr) begin
            check_flag(prev_out_rdy, 1'b1, "out_rdy in the cycle before out_wr");
         end
         if (proc_req && !prev_req) begin
            check_flag(pkts_sent > req_count, 1'b1, "whole packet sent before proc_req");
            req_count++;
            holding   = 1'b1;
            pkt_words = 0;
            err_base  = error_count;
         end
         if (holding) begin
            check_flag(in_rdy, 1'b0, "in_rdy while the packet is held");
         end
         if (out_wr) begin
            got = {out_ctrl, out_data};
            if (exp_q.size() == 0) begin
               error_count++;
               $display("** Error %0t: output word %h with none expected", $time, got);
            end else begin
               check_word(got, exp_q.pop_front(), "output word");
               pkt_words++;
               if (exp_q.size() == 0 && holding) begin
                  holding = 1'b0;
                  pkts_done++;
                  $display("packet %0d: %0d words out, %0d errors",
                           pkts_done, pkt_words, error_count - err_base);
               end
            end
         end
         prev_req     = proc_req;
         out_rdy      = ($urandom_range(3) != 0);
         prev_out_rdy = out_rdy;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // run
   //////////////////////////////////////////////////////////////////////

   initial begin
      seed_value = 32'hc9ab_7eba;
      void'($urandom(seed_value));
      reset        = 1'b1;
      in_data      = '0;
      in_ctrl      = '0;
      in_wr        = 1'b0;
      out_rdy      = 1'b0;
      proc_ack     = 1'b0;
      proc_wr_en   = 1'b0;
      proc_addr    = '0;
      proc_wdata   = '0;
      pkts_sent    = 0;
      pkts_done    = 0;
      req_count    = 0;
      error_count  = 0;
      check_count  = 0;
      holding      = 1'b0;
      prev_req     = 1'b0;
      prev_out_rdy = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      check_flag(out_wr, 1'b0, "out_wr after reset");
      check_flag(proc_req, 1'b0, "proc_req after reset");
      check_flag(in_rdy, 1'b1, "in_rdy after reset");
      $display("reset: %0d errors", error_count);
      fork
         send_packets();
         run_agent();
         watch_output();
      join_none
      wait (pkts_done == num_pkts);
      // a few more cycles to catch stray words
      repeat (8) @(posedge clk);
      if (sent_q.size() != 0 || exp_q.size() != 0 || req_count != num_pkts) begin
         error_count++;
         $display("model out of step: %0d words unsent, %0d words not seen, %0d requests",
                  sent_q.size(), exp_q.size(), req_count);
      end
      $display("tests %0d, checks %0d, errors %0d", num_pkts + 1, check_count, error_count);
      if (error_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   // four times the longest packet plus slack for every packet
   initial begin
      cycles = 0;
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run not finished after %0d cycles, %0d of %0d packets drained",
               cycles, pkts_done, num_pkts);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// ==== pkt_proc.f ====
+incdir+include
hw/pkt_proc_pkg.sv
hw/input_fifo.sv
hw/packet_buffer.sv
hw/packet_sequencer.sv
hw/pkt_proc_top.sv
dv/pkt_proc_tb.sv

// ==== Bender.yml ====
package:
  name: pkt_proc

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/pkt_proc_pkg.sv
      - hw/input_fifo.sv
      - hw/packet_buffer.sv
      - hw/packet_sequencer.sv
      - hw/pkt_proc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/pkt_proc_tb.sv
